// File: rtl/mont_types_pkg.sv
package mont_types_pkg;

	// width of one modulus word
	localparam int WORD_BITS = 16;

	typedef logic [WORD_BITS-1:0] word_t;

	// word index into modulus memory and output stream
	typedef logic [7:0] word_addr_t;

	// read request to the modulus memory
	typedef struct packed {
		logic       en;
		word_addr_t addr;
	} mod_rd_t;

	// which constant an output word belongs to
	typedef enum logic {
		KIND_T = 1'b0,
		KIND_R = 1'b1
	} const_kind_t;

	// one output word
	typedef struct packed {
		logic        valid;
		const_kind_t kind;
		word_addr_t  addr;
		word_t       data;
	} out_beat_t;

endpackage

// File: rtl/mont_fsm_pkg.sv
package mont_fsm_pkg;

	// handshake and modulus fetch
	typedef enum logic [1:0] {
		LD_IDLE,
		LD_FETCH,
		LD_WAIT,
		LD_ACK
	} load_state_t;

	// doubling loop
	typedef enum logic {
		ENG_IDLE,
		ENG_RUN
	} eng_state_t;

	// output stream, t words first
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_T,
		ST_R
	} strm_state_t;

endpackage

// File: rtl/modulus_loader.sv
`timescale 1ns/10ps

module modulus_loader
	import mont_types_pkg::*;
	import mont_fsm_pkg::*;
#(
	parameter int NUM_WORDS = 4
) (
	input  logic                  CLK,
	input  logic                  RST_N,
	input  logic                  req,
	output logic                  ack,
	output mod_rd_t               mod_rd,
	input  word_t                 mod_rd_data,
	input  logic                  stream_end,
	output logic                  start,
	output word_t [NUM_WORDS-1:0] modulus
);

	localparam word_addr_t LAST_ADDR = word_addr_t'(NUM_WORDS - 1);

	load_state_t state;

	// request of the previous cycle, matches mod_rd_data
	mod_rd_t     rd_pend;

	//////////////////////////////
	// handshake and read sequencing
	//////////////////////////////

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state   <= LD_IDLE;
			mod_rd  <= '0;
			rd_pend <= '0;
			start   <= 1'b0;
		end else begin
			rd_pend <= mod_rd;
			// engine kicks off once the top word is in
			start   <= rd_pend.en && (rd_pend.addr == LAST_ADDR);

			case (state)
				LD_IDLE: begin
					if (req) begin
						mod_rd.en   <= 1'b1;
						mod_rd.addr <= '0;
						state       <= LD_FETCH;
					end
				end

				LD_FETCH: begin
					if (mod_rd.addr == LAST_ADDR) begin
						mod_rd.en <= 1'b0;
						state     <= LD_WAIT;
					end else begin
						mod_rd.addr <= mod_rd.addr + word_addr_t'(1);
					end
				end

				// engine and streamer busy
				LD_WAIT: begin
					if (stream_end) begin
						state <= LD_ACK;
					end
				end

				// hold ack until the requester lets go
				LD_ACK: begin
					if (!req) begin
						state <= LD_IDLE;
					end
				end

				default: begin
					state <= LD_IDLE;
				end
			endcase
		end
	end

	assign ack = (state == LD_ACK);

	//////////////////////////////
	// modulus capture
	//////////////////////////////

	always_ff @(posedge CLK) begin
		if (rd_pend.en) begin
			modulus[rd_pend.addr] <= mod_rd_data;
		end
	end

endmodule

// File: rtl/residue_engine.sv
`timescale 1ns/10ps

module residue_engine
	import mont_types_pkg::*;
	import mont_fsm_pkg::*;
#(
	parameter int NUM_WORDS = 4
) (
	input  logic                  CLK,
	input  logic                  RST_N,
	input  logic                  start,
	input  word_t [NUM_WORDS-1:0] modulus,
	output logic                  done,
	output word_t [NUM_WORDS-1:0] r_val,
	output word_t [NUM_WORDS-1:0] t_val
);

	localparam int K        = NUM_WORDS * WORD_BITS;
	localparam int CNT_BITS = $clog2(2 * K);

	// the start cycle already takes the first step,
	// so cnt trails the finished step count by two
	localparam int R_STEP = K - 2;
	localparam int T_STEP = 2 * K - 2;

	typedef logic [K:0]          acc_t;
	typedef logic [K+1:0]        dbl_t;
	typedef logic [CNT_BITS-1:0] cnt_t;

	eng_state_t state;
	cnt_t       cnt;
	acc_t       acc;
	acc_t       seed;
	acc_t       acc_nxt;
	dbl_t       dbl;
	dbl_t       mod_ext;

	//////////////////////////////
	// one modular doubling step
	//////////////////////////////

	always_comb begin
		// a fresh run starts from 1
		seed    = start ? acc_t'(1) : acc;
		dbl     = {seed, 1'b0};
		mod_ext = {2'b00, modulus};
		if (dbl >= mod_ext) begin
			acc_nxt = acc_t'(dbl - mod_ext);
		end else begin
			acc_nxt = acc_t'(dbl);
		end
	end

	//////////////////////////////
	// step control
	//////////////////////////////

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= ENG_IDLE;
			cnt   <= '0;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				ENG_IDLE: begin
					if (start) begin
						cnt   <= '0;
						state <= ENG_RUN;
					end
				end

				ENG_RUN: begin
					cnt <= cnt + cnt_t'(1);
					if (cnt == cnt_t'(T_STEP)) begin
						done  <= 1'b1;
						state <= ENG_IDLE;
					end
				end

				default: begin
					state <= ENG_IDLE;
				end
			endcase
		end
	end

	// accumulator and results
	always_ff @(posedge CLK) begin
		if (start || state == ENG_RUN) begin
			acc <= acc_nxt;
		end
		if (state == ENG_RUN && cnt == cnt_t'(R_STEP)) begin
			r_val <= acc_nxt[K-1:0];
		end
		if (state == ENG_RUN && cnt == cnt_t'(T_STEP)) begin
			t_val <= acc_nxt[K-1:0];
		end
	end

endmodule

// File: rtl/constant_streamer.sv
`timescale 1ns/10ps

module constant_streamer
	import mont_types_pkg::*;
	import mont_fsm_pkg::*;
#(
	parameter int NUM_WORDS = 4
) (
	input  logic                  CLK,
	input  logic                  RST_N,
	input  logic                  done,
	input  word_t [NUM_WORDS-1:0] r_val,
	input  word_t [NUM_WORDS-1:0] t_val,
	output out_beat_t             beat,
	output logic                  stream_end
);

	localparam word_addr_t LAST_ADDR = word_addr_t'(NUM_WORDS - 1);

	strm_state_t state;

	// address of the beat now on the output
	word_addr_t  wcnt;
	word_addr_t  wnxt;

	function automatic out_beat_t mk_beat(const_kind_t kind, word_addr_t addr, word_t data);
		out_beat_t b;
		b.valid = 1'b1;
		b.kind  = kind;
		b.addr  = addr;
		b.data  = data;
		return b;
	endfunction

	assign wnxt = wcnt + word_addr_t'(1);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state      <= ST_IDLE;
			wcnt       <= '0;
			beat       <= '0;
			stream_end <= 1'b0;
		end else begin
			beat.valid <= 1'b0;
			stream_end <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (done) begin
						beat  <= mk_beat(KIND_T, '0, t_val[0]);
						wcnt  <= '0;
						state <= ST_T;
					end
				end

				// t words, then straight into r with no gap
				ST_T: begin
					if (wcnt == LAST_ADDR) begin
						beat  <= mk_beat(KIND_R, '0, r_val[0]);
						wcnt  <= '0;
						state <= ST_R;
					end else begin
						beat <= mk_beat(KIND_T, wnxt, t_val[wnxt]);
						wcnt <= wnxt;
					end
				end

				ST_R: begin
					if (wcnt == LAST_ADDR) begin
						state <= ST_IDLE;
					end else begin
						beat       <= mk_beat(KIND_R, wnxt, r_val[wnxt]);
						wcnt       <= wnxt;
						stream_end <= (wnxt == LAST_ADDR);
					end
				end

				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

// File: rtl/mont_const_top.sv
`timescale 1ns/10ps

module mont_const_top
	import mont_types_pkg::*;
#(
	parameter int NUM_WORDS = 4
) (
	input  logic      CLK,
	input  logic      RST_N,
	input  logic      req,
	output logic      ack,
	output mod_rd_t   mod_rd,
	input  word_t     mod_rd_data,
	output out_beat_t beat
);

	logic                      start;
	logic                      done;
	logic                      stream_end;
	word_t [NUM_WORDS-1:0]     modulus;
	word_t [NUM_WORDS-1:0]     r_val;
	word_t [NUM_WORDS-1:0]     t_val;

	modulus_loader #(.NUM_WORDS(NUM_WORDS)) u_loader (
		.CLK         (CLK),
		.RST_N       (RST_N),
		.req         (req),
		.ack         (ack),
		.mod_rd      (mod_rd),
		.mod_rd_data (mod_rd_data),
		.stream_end  (stream_end),
		.start       (start),
		.modulus     (modulus)
	);

	residue_engine #(.NUM_WORDS(NUM_WORDS)) u_engine (
		.CLK     (CLK),
		.RST_N   (RST_N),
		.start   (start),
		.modulus (modulus),
		.done    (done),
		.r_val   (r_val),
		.t_val   (t_val)
	);

	constant_streamer #(.NUM_WORDS(NUM_WORDS)) u_streamer (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.done       (done),
		.r_val      (r_val),
		.t_val      (t_val),
		.beat       (beat),
		.stream_end (stream_end)
	);

endmodule

// File: tests/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// one fixed case: modulus, expected 2^K mod N, expected 2^(2K) mod N
typedef struct packed {
	val_t n;
	val_t r;
	val_t t;
} vec_t;

localparam int NUM_FIXED = 4;

localparam vec_t FIXED_VECS [NUM_FIXED] = '{
	// smallest odd modulus above one
	'{64'h0000_0000_0000_0003, 64'h0000_0000_0000_0001, 64'h0000_0000_0000_0001},
	// all ones, 2^K is one above N
	'{64'hFFFF_FFFF_FFFF_FFFF, 64'h0000_0000_0000_0001, 64'h0000_0000_0000_0001},
	// 2^63 + 1, so 2^64 is -2
	'{64'h8000_0000_0000_0001, 64'h7FFF_FFFF_FFFF_FFFF, 64'h0000_0000_0000_0004},
	// 2^64 - 59
	'{64'hFFFF_FFFF_FFFF_FFC5, 64'h0000_0000_0000_003B, 64'h0000_0000_0000_0D99}
};

`endif

// File: tests/tb_mont_const.sv
`timescale 1ns/10ps

module tb_mont_const
	import mont_types_pkg::*;
();

	localparam int NUM_WORDS  = 4;
	localparam int K          = NUM_WORDS * WORD_BITS;
	localparam int PERIOD     = 100;
	localparam int NUM_RANDOM = 8;

	typedef logic [K-1:0] val_t;

`include "tb_vectors.svh"

	localparam int NUM_CASES       = NUM_FIXED + NUM_RANDOM;
	localparam int WATCHDOG_CYCLES = NUM_CASES * (2 * K + 4 * NUM_WORDS + 40);

	logic      CLK;
	logic      RST_N;
	logic      req;
	logic      ack;
	mod_rd_t   mod_rd;
	word_t     mod_rd_data = '0;
	out_beat_t beat;

	// modulus of the case now running
	val_t        mem_n       = '0;
	mod_rd_t     rd_seen     = '0;
	logic [15:0] lfsr_state  = 16'd40894;
	int          cycle       = 0;

	mont_const_top #(.NUM_WORDS(NUM_WORDS)) UUT (
		.CLK         (CLK),
		.RST_N       (RST_N),
		.req         (req),
		.ack         (ack),
		.mod_rd      (mod_rd),
		.mod_rd_data (mod_rd_data),
		.beat        (beat)
	);

	initial begin
		CLK = 1'b0;
		forever #(PERIOD / 2) CLK = ~CLK;
	end

	always @(posedge CLK) cycle <= cycle + 1;

	//////////////////////////////
	// modulus memory, one cycle latency
	//////////////////////////////

	always @(negedge CLK) rd_seen <= mod_rd;

	always @(posedge CLK) begin
		#5;
		if (rd_seen.en) begin
			mod_rd_data = mem_n[rd_seen.addr * WORD_BITS +: WORD_BITS];
		end
	end

	//////////////////////////////
	// checks and reference
	//////////////////////////////

	task automatic check_value(input string name, input val_t got, input val_t exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	task automatic protocol_error(input string what);
		$display("error: %s", what);
		$display("sim failed");
		$fatal(1);
	endtask

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic [15:0] nxt;
		nxt = s >> 1;
		if (s[0]) begin
			nxt = nxt ^ 16'hB400;
		end
		return nxt;
	endfunction

	// one lfsr step per modulus bit, odd by force
	task automatic draw_modulus(output val_t n);
		n = '0;
		for (int i = 0; i < K; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			n[i] = lfsr_state[0];
		end
		n[0] = 1'b1;
	endtask

	// 2K modular doublings from 1, value after K steps is r
	task automatic compute_reference(input val_t n, output val_t r, output val_t t);
		logic [K+1:0] acc;
		logic [K+1:0] n_ext;
		acc   = '0;
		acc[0] = 1'b1;
		n_ext = {2'b00, n};
		r     = '0;
		for (int step = 1; step <= 2 * K; step++) begin
			acc = acc << 1;
			if (acc >= n_ext) begin
				acc = acc - n_ext;
			end
			if (step == K) begin
				r = val_t'(acc);
			end
		end
		t = val_t'(acc);
	endtask

	task automatic check_quiet();
		check_value("mod_rd.en", val_t'(mod_rd.en), val_t'(0));
		check_value("beat.valid", val_t'(beat.valid), val_t'(0));
	endtask

	//////////////////////////////
	// one handshake run
	//////////////////////////////

	task automatic run_case(input val_t n, input val_t exp_r, input val_t exp_t);
		int   reads;
		int   beats;
		int   first_read;
		int   first_beat;
		val_t got_r;
		val_t got_t;
		logic got_ack;
		mem_n      = n;
		reads      = 0;
		beats      = 0;
		first_read = 0;
		first_beat = 0;
		got_r      = '0;
		got_t      = '0;
		got_ack    = 1'b0;
		@(posedge CLK);
		#5;
		req = 1'b1;
		while (!got_ack) begin
			@(negedge CLK);
			if (mod_rd.en) begin
				if (beats != 0 || reads == NUM_WORDS) begin
					protocol_error("modulus read outside the fetch phase");
				end
				if (reads == 0) begin
					first_read = cycle;
				end
				check_value("mod_rd.addr", val_t'(mod_rd.addr), val_t'(reads));
				reads++;
			end
			if (beat.valid) begin
				if (reads != NUM_WORDS) begin
					protocol_error("output beat before the modulus was fully read");
				end
				if (beats == 2 * NUM_WORDS) begin
					protocol_error("more output beats than the two constants hold");
				end
				if (beats == 0) begin
					first_beat = cycle;
					check_value("first beat latency", val_t'(cycle - first_read),
						val_t'(NUM_WORDS + 2 + 2 * K));
				end
				// back to back beats
				check_value("beat cycle", val_t'(cycle), val_t'(first_beat + beats));
				if (beats < NUM_WORDS) begin
					check_value("beat.kind", val_t'(beat.kind), val_t'(KIND_T));
					check_value("beat.addr", val_t'(beat.addr), val_t'(beats));
					got_t[beat.addr * WORD_BITS +: WORD_BITS] = beat.data;
				end else begin
					check_value("beat.kind", val_t'(beat.kind), val_t'(KIND_R));
					check_value("beat.addr", val_t'(beat.addr), val_t'(beats - NUM_WORDS));
					got_r[beat.addr * WORD_BITS +: WORD_BITS] = beat.data;
				end
				beats++;
			end
			if (ack) begin
				if (beats != 2 * NUM_WORDS) begin
					protocol_error("ack raised before the last output beat");
				end
				got_ack = 1'b1;
			end
		end
		check_value("r", got_r, exp_r);
		check_value("t", got_t, exp_t);

		// ack stays up while req is held
		repeat (3) begin
			@(negedge CLK);
			check_value("ack", val_t'(ack), val_t'(1));
			check_quiet();
		end
		@(posedge CLK);
		#5;
		req = 1'b0;
		repeat (2) @(negedge CLK);
		check_value("ack", val_t'(ack), val_t'(0));
		repeat (3) begin
			@(negedge CLK);
			check_value("ack", val_t'(ack), val_t'(0));
			check_quiet();
		end
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial begin
		val_t n;
		val_t exp_r;
		val_t exp_t;
		RST_N = 1'b0;
		req   = 1'b0;
		repeat (8) @(posedge CLK);
		#5;
		RST_N = 1'b1;

		// idle outputs before any request
		repeat (3) begin
			@(negedge CLK);
			check_value("ack", val_t'(ack), val_t'(0));
			check_quiet();
		end

		for (int i = 0; i < NUM_FIXED; i++) begin
			run_case(FIXED_VECS[i].n, FIXED_VECS[i].r, FIXED_VECS[i].t);
		end

		for (int i = 0; i < NUM_RANDOM; i++) begin
			draw_modulus(n);
			compute_reference(n, exp_r, exp_t);
			run_case(n, exp_r, exp_t);
		end

		$display("sim passed");
		$finish;
	end

	// watchdog over all cases
	initial begin
		#(WATCHDOG_CYCLES * PERIOD);
		$display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("sim failed");
		$fatal(1);
	end

endmodule

// File: project.f
+incdir+tests
rtl/mont_types_pkg.sv
rtl/mont_fsm_pkg.sv
rtl/modulus_loader.sv
rtl/residue_engine.sv
rtl/constant_streamer.sv
rtl/mont_const_top.sv
tests/tb_mont_const.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := tb_mont_const
FILELIST  := project.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
